//--- logic/hdc_cfg.svh
`ifndef HDC_CFG_SVH
`define HDC_CFG_SVH

// ------------------------------------------------------------
// hypervector geometry
// ------------------------------------------------------------
// bits per random word
`define HDC_WORD_W 32
// words per hypervector, 8 gives 256 bits, 32 gives 1024
`define HDC_WORDS 8
// item address width, up to 1024 items
`define HDC_ITEM_ADDR_W 10
// xorshift start value, reloaded whenever gen is low
`define HDC_SEED 32'h2545F491

// ------------------------------------------------------------
// axi-lite bus
// ------------------------------------------------------------
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
// addr bits 11:10 value of the register block
`define AXIL_REG_REGION 0

`endif

//--- logic/axil_pkg.sv
package axil_pkg;

    // slave channel fsm
    typedef enum logic [2:0] {
        idle        = 3'd0,
        // aw taken, waiting for w
        addr_only   = 3'd1,
        // w taken, waiting for aw
        data_only   = 3'd2,
        write_resp  = 3'd3,
        // one cycle for the register read mux
        read_decode = 3'd4,
        read_resp   = 3'd5
    } axil_state_e;

    // bresp / rresp encoding
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t OKAY = 2'b00;

endpackage

//--- logic/hdc_pkg.sv
`include "hdc_cfg.svh"

package hdc_pkg;

    // one prng word
    typedef logic [`HDC_WORD_W-1:0] word_t;

    // full hypervector, word 0 in the low bits
    typedef word_t [`HDC_WORDS-1:0] vector_t;

    // item address, also used for the item count
    typedef logic [`HDC_ITEM_ADDR_W-1:0] item_addr_t;

    // slot of a word inside one vector
    typedef logic [$clog2(`HDC_WORDS)-1:0] word_idx_t;

    // byte offsets inside the register block
    typedef enum logic [9:0] {
        // bit 0 gen, bit 1 reads 0
        REG_CTRL     = 10'h000,
        // last item address N
        REG_ITEM_NUM = 10'h004
    } reg_offset_e;

endpackage

//--- logic/axil_slave.sv
`include "hdc_cfg.svh"

`default_nettype none

module axil_slave (
    input  logic                      AXIS_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic [`AXIL_ADDR_W-1:0]   s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  logic [`AXIL_DATA_W-1:0]   s_axi_wdata,
    input  logic [`AXIL_DATA_W/8-1:0] s_axi_wstrb,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    input  logic                      s_axi_bready,
    output axil_pkg::axil_resp_t      s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic [`AXIL_ADDR_W-1:0]   s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    input  logic                      s_axi_rready,
    output axil_pkg::axil_resp_t      s_axi_rresp,
    output logic                      s_axi_rvalid,
    output logic                      reg_wr,
    output logic                      reg_rd,
    output logic [11:2]               wr_addr,
    output logic [`AXIL_DATA_W-1:0]   wr_data,
    output logic [11:2]               rd_addr
);
    import axil_pkg::*;

    axil_state_e state;
    logic        aw_hs;
    logic        w_hs;
    logic        ar_hs;

    // ------------------------------------------------------------
    // channel handshakes
    // ------------------------------------------------------------
    assign s_axi_awready = (state == idle) || (state == data_only);
    assign s_axi_wready  = (state == idle) || (state == addr_only);
    // read yields to a pending write in idle
    assign s_axi_arready = (state == idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == write_resp);
    assign s_axi_rvalid  = (state == read_resp);
    assign s_axi_bresp   = OKAY;
    assign s_axi_rresp   = OKAY;

    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;
    assign ar_hs = s_axi_arvalid && s_axi_arready;

    // register strobes
    assign reg_wr = (state == write_resp);
    assign reg_rd = (state == read_decode);

    // ------------------------------------------------------------
    // fsm
    // ------------------------------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (aw_hs && w_hs) begin
                        state <= write_resp;
                    end else if (aw_hs) begin
                        state <= addr_only;
                    end else if (w_hs) begin
                        state <= data_only;
                    end else if (ar_hs) begin
                        state <= read_decode;
                    end
                end
                addr_only:   if (w_hs) state <= write_resp;
                data_only:   if (aw_hs) state <= write_resp;
                // held until the master takes the response
                write_resp:  if (s_axi_bready) state <= idle;
                read_decode: state <= read_resp;
                read_resp:   if (s_axi_rready) state <= idle;
                default:     state <= idle;
            endcase
        end
    end

    // address and data capture, word address only
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_hs) wr_addr <= s_axi_awaddr[11:2];
        if (w_hs) wr_data <= s_axi_wdata;
        if (ar_hs) rd_addr <= s_axi_araddr[11:2];
    end

endmodule

`default_nettype wire

//--- logic/ctrl_regs.sv
`include "hdc_cfg.svh"

`default_nettype none

module ctrl_regs (
    input  logic                    AXIS_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic                    reg_wr,
    input  logic                    reg_rd,
    input  logic [11:2]             wr_addr,
    input  logic [`AXIL_DATA_W-1:0] wr_data,
    input  logic [11:2]             rd_addr,
    input  logic                    item_valid,
    input  hdc_pkg::item_addr_t     item_addr,
    output logic                    gen,
    output logic [`AXIL_DATA_W-1:0] rdata
);
    import hdc_pkg::*;

    item_addr_t              item_num;
    logic                    wr_hit;
    logic                    rd_hit;
    reg_offset_e             wr_off;
    reg_offset_e             rd_off;
    logic                    last_item;
    logic [`AXIL_DATA_W-1:0] rd_word;

    // region select on addr bits 11:10
    assign wr_hit = reg_wr && (wr_addr[11:10] == 2'(`AXIL_REG_REGION));
    assign rd_hit = rd_addr[11:10] == 2'(`AXIL_REG_REGION);
    assign wr_off = reg_offset_e'({wr_addr[9:2], 2'b00});
    assign rd_off = reg_offset_e'({rd_addr[9:2], 2'b00});

    // item N is out, stop after this edge
    assign last_item = gen && item_valid && (item_addr == item_num);

    // ------------------------------------------------------------
    // register write and gen auto-clear
    // ------------------------------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen      <= 1'b0;
            item_num <= '0;
        end else begin
            if (last_item) gen <= 1'b0;
            // bus write wins over the auto-clear
            if (wr_hit) begin
                case (wr_off)
                    REG_CTRL:     gen <= wr_data[0];
                    REG_ITEM_NUM: item_num <= wr_data[`HDC_ITEM_ADDR_W-1:0];
                    default:      ;
                endcase
            end
        end
    end

    // read mux, unmapped reads 0
    always_comb begin
        rd_word = '0;
        if (rd_hit) begin
            case (rd_off)
                REG_CTRL:     rd_word[0] = gen;
                REG_ITEM_NUM: rd_word[`HDC_ITEM_ADDR_W-1:0] = item_num;
                default:      ;
            endcase
        end
    end

    // loaded in read_decode, shown in read_resp
    always_ff @(posedge AXIS_ACLK) begin
        if (reg_rd) rdata <= rd_word;
    end

endmodule

`default_nettype wire

//--- logic/xorshift_prng.sv
`include "hdc_cfg.svh"

`default_nettype none

module xorshift_prng (
    input  logic           AXIS_ACLK,
    input  logic           S_AXI_ARESETN,
    input  logic           gen,
    output hdc_pkg::word_t rand_word
);
    import hdc_pkg::*;

    word_t state;
    word_t step_a;
    word_t step_b;
    word_t step_c;

    // xorshift32, shifts 13 / 17 / 5
    assign step_a = state ^ (state << 13);
    assign step_b = step_a ^ (step_a >> 17);
    assign step_c = step_b ^ (step_b << 5);

    // seed held while idle, one step per cycle while gen
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            state <= `HDC_SEED;
        end else begin
            state <= step_c;
        end
    end

    assign rand_word = state;

endmodule

`default_nettype wire

//--- logic/item_vector_gen.sv
`include "hdc_cfg.svh"

`default_nettype none

module item_vector_gen (
    input  logic                AXIS_ACLK,
    input  logic                S_AXI_ARESETN,
    input  logic                gen,
    input  hdc_pkg::word_t      rand_word,
    output logic                item_valid,
    output hdc_pkg::item_addr_t item_addr,
    output hdc_pkg::vector_t    item_vector
);
    import hdc_pkg::*;

    localparam word_idx_t LAST_SLOT = word_idx_t'(`HDC_WORDS - 1);

    word_idx_t word_cnt;
    logic      vec_done;

    // last word goes in this cycle
    assign vec_done = (word_cnt == LAST_SLOT);

    // ------------------------------------------------------------
    // word counter
    // ------------------------------------------------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            word_cnt <= '0;
        end else if (vec_done) begin
            word_cnt <= '0;
        end else begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // item strobe and address
    // ------------------------------------------------------------
    // one cycle after the last slot fills
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            item_valid <= 1'b0;
            item_addr  <= '0;
        end else begin
            item_valid <= vec_done;
            // next address once the current item was shown
            if (item_valid) item_addr <= item_addr + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // vector assembly
    // ------------------------------------------------------------
    // slot 0 of the next vector is written in the strobe cycle,
    // so the presented vector is still whole during item_valid
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            item_vector <= '0;
        end else begin
            item_vector[word_cnt] <= rand_word;
        end
    end

endmodule

`default_nettype wire

//--- logic/hdc_top.sv
`include "hdc_cfg.svh"

`default_nettype none

module hdc_top (
    input  logic                      AXIS_ACLK,
    input  logic                      S_AXI_ARESETN,
    input  logic [`AXIL_ADDR_W-1:0]   s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  logic [`AXIL_DATA_W-1:0]   s_axi_wdata,
    input  logic [`AXIL_DATA_W/8-1:0] s_axi_wstrb,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    input  logic                      s_axi_bready,
    output axil_pkg::axil_resp_t      s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic [`AXIL_ADDR_W-1:0]   s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    input  logic                      s_axi_rready,
    output logic [`AXIL_DATA_W-1:0]   s_axi_rdata,
    output axil_pkg::axil_resp_t      s_axi_rresp,
    output logic                      s_axi_rvalid,
    output logic                      item_valid,
    output hdc_pkg::item_addr_t       item_addr,
    output hdc_pkg::vector_t          item_vector
);
    import hdc_pkg::*;

    // ------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------
    logic                    reg_wr;
    logic                    reg_rd;
    logic [11:2]             wr_addr;
    logic [11:2]             rd_addr;
    logic [`AXIL_DATA_W-1:0] wr_data;
    logic                    gen;
    word_t                   rand_word;

    // bus side
    axil_slave u_axil_slave (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr)
    );

    // gen / item count, rdata straight to the port
    ctrl_regs u_ctrl_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr),
        .item_valid    (item_valid),
        .item_addr     (item_addr),
        .gen           (gen),
        .rdata         (s_axi_rdata)
    );

    // random word source
    xorshift_prng u_prng (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .rand_word     (rand_word)
    );

    // item memory vectors
    item_vector_gen u_item_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .rand_word     (rand_word),
        .item_valid    (item_valid),
        .item_addr     (item_addr),
        .item_vector   (item_vector)
    );

endmodule

`default_nettype wire

//--- tests/hdc_checker.sv
`include "hdc_cfg.svh"

module hdc_checker (
    input  logic                    AXIS_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  axil_pkg::axil_resp_t    s_axi_bresp,
    input  logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,
    input  axil_pkg::axil_resp_t    s_axi_rresp,
    input  logic [`AXIL_DATA_W-1:0] s_axi_rdata,
    input  logic                    item_valid,
    input  hdc_pkg::item_addr_t     item_addr,
    input  hdc_pkg::vector_t        item_vector,
    input  logic [`AXIL_DATA_W-1:0] exp_rdata,
    input  logic                    run_start,
    input  int                      last_n,
    output int                      items_seen,
    output int                      errors,
    output int                      checks
);
    import axil_pkg::*;
    import hdc_pkg::*;

    int seen_cnt = 0;
    int err_cnt = 0;
    int chk_cnt = 0;
    int rst_cycles = 0;

    assign items_seen = seen_cnt;
    assign errors     = err_cnt;
    assign checks     = chk_cnt;

    // word k of the stream, xorshift32 applied k times to the seed
    function automatic logic [31:0] ref_word(input int k);
        logic [31:0] x;
        x = `HDC_SEED;
        for (int i = 0; i < k; i++) begin
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
        end
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // sampled on the falling edge, all dut outputs settled
    // ------------------------------------------------------------
    always @(negedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rst_cycles++;
            // first reset edge has passed by the second sample
            if (rst_cycles > 1) begin
                compare_value("s_axi_bvalid", 32'd0, 32'(s_axi_bvalid));
                compare_value("s_axi_rvalid", 32'd0, 32'(s_axi_rvalid));
                compare_value("item_valid", 32'd0, 32'(item_valid));
            end
        end else begin
            // new run, sequence and addresses start over
            if (run_start) begin
                seen_cnt = 0;
            end
            if (s_axi_bvalid && s_axi_bready) begin
                compare_value("s_axi_bresp", 32'(OKAY), 32'(s_axi_bresp));
            end
            if (s_axi_rvalid && s_axi_rready) begin
                compare_value("s_axi_rdata", exp_rdata, s_axi_rdata);
                compare_value("s_axi_rresp", 32'(OKAY), 32'(s_axi_rresp));
            end
            if (item_valid) begin
                if (seen_cnt > last_n) begin
                    err_cnt++;
                    $display("error at %0t: item_valid pulse after the last item %0d",
                             $time, last_n);
                end else begin
                    compare_value("item_addr", 32'(seen_cnt), 32'(item_addr));
                    // item i word j is stream word i*words+j
                    for (int j = 0; j < `HDC_WORDS; j++) begin
                        compare_value($sformatf("item_vector[%0d]", j),
                                      ref_word(seen_cnt * `HDC_WORDS + j),
                                      item_vector[word_idx_t'(j)]);
                    end
                end
                seen_cnt++;
            end
        end
    end

endmodule

//--- tests/hdc_top_sva.sv
module hdc_top_sva (
    input logic AXIS_ACLK,
    input logic S_AXI_ARESETN,
    input logic s_axi_bvalid,
    input logic s_axi_bready,
    input logic s_axi_rvalid,
    input logic item_valid
);

    // write and read responses share one fsm
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid))
        else $error("bvalid and rvalid high in the same cycle");

    // b channel holds until taken
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    // one strobe per vector
    assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        item_valid |=> !item_valid)
        else $error("item_valid high two cycles in a row");

endmodule

bind hdc_top hdc_top_sva u_sva (
    .AXIS_ACLK     (AXIS_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_rvalid  (s_axi_rvalid),
    .item_valid    (item_valid)
);

//--- tests/tb_hdc_top.sv
`include "hdc_cfg.svh"

module tb_hdc_top;
    import axil_pkg::*;
    import hdc_pkg::*;

    localparam int TIMEOUT = 200;

    logic                      AXIS_ACLK;
    logic                      S_AXI_ARESETN;
    logic [`AXIL_ADDR_W-1:0]   s_axi_awaddr;
    logic                      s_axi_awvalid;
    logic                      s_axi_awready;
    logic [`AXIL_DATA_W-1:0]   s_axi_wdata;
    logic [`AXIL_DATA_W/8-1:0] s_axi_wstrb;
    logic                      s_axi_wvalid;
    logic                      s_axi_wready;
    logic                      s_axi_bready;
    axil_resp_t                s_axi_bresp;
    logic                      s_axi_bvalid;
    logic [`AXIL_ADDR_W-1:0]   s_axi_araddr;
    logic                      s_axi_arvalid;
    logic                      s_axi_arready;
    logic                      s_axi_rready;
    logic [`AXIL_DATA_W-1:0]   s_axi_rdata;
    axil_resp_t                s_axi_rresp;
    logic                      s_axi_rvalid;
    logic                      item_valid;
    item_addr_t                item_addr;
    vector_t                   item_vector;

    // checker side
    logic [`AXIL_DATA_W-1:0]   exp_rdata;
    logic                      run_start;
    int                        last_n;
    int                        items_seen;
    int                        errors;
    int                        checks;
    logic                      aborted;

    hdc_top uut (.*);

    hdc_checker u_checker (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rdata   (s_axi_rdata),
        .item_valid    (item_valid),
        .item_addr     (item_addr),
        .item_vector   (item_vector),
        .exp_rdata     (exp_rdata),
        .run_start     (run_start),
        .last_n        (last_n),
        .items_seen    (items_seen),
        .errors        (errors),
        .checks        (checks)
    );

    initial begin
        AXIS_ACLK = 1'b0;
        forever #2 AXIS_ACLK = ~AXIS_ACLK;
    end

    // ------------------------------------------------------------
    // bus helpers driving inputs 1 unit after the edge
    // ------------------------------------------------------------
    task automatic next_cycle();
        @(posedge AXIS_ACLK);
        #1;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: gave up waiting for %s", $time, what);
        aborted = 1'b1;
    endtask

    // order 0 aw+w together, 1 aw first, 2 w first
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data, input int order);
        logic aw_done;
        logic w_done;
        logic aw_now;
        logic w_now;
        logic b_done;
        int   wait_cnt;
        aw_done = 1'b0;
        w_done  = 1'b0;
        b_done  = 1'b0;
        wait_cnt = 0;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = (order != 2);
        s_axi_wvalid  = (order != 1);
        while (!(aw_done && w_done) && !aborted) begin
            @(negedge AXIS_ACLK);
            aw_now = s_axi_awvalid && s_axi_awready;
            w_now  = s_axi_wvalid && s_axi_wready;
            next_cycle();
            if (aw_now) begin
                aw_done = 1'b1;
                s_axi_awvalid = 1'b0;
            end
            if (w_now) begin
                w_done = 1'b1;
                s_axi_wvalid = 1'b0;
            end
            // second channel follows once the first is taken
            if (aw_done && !w_done) s_axi_wvalid = 1'b1;
            if (w_done && !aw_done) s_axi_awvalid = 1'b1;
            wait_cnt++;
            if (!(aw_done && w_done) && wait_cnt > TIMEOUT) report_timeout("aw/w handshake");
        end
        // bready sometimes late
        repeat ($urandom_range(3, 0)) next_cycle();
        s_axi_bready = 1'b1;
        wait_cnt = 0;
        while (!b_done && !aborted) begin
            @(negedge AXIS_ACLK);
            b_done = s_axi_bvalid;
            next_cycle();
            wait_cnt++;
            if (!b_done && wait_cnt > TIMEOUT) report_timeout("write response");
        end
        s_axi_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [31:0] expected);
        logic ar_done;
        logic r_done;
        int   wait_cnt;
        ar_done  = 1'b0;
        r_done   = 1'b0;
        wait_cnt = 0;
        exp_rdata     = expected;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        while (!ar_done && !aborted) begin
            @(negedge AXIS_ACLK);
            ar_done = s_axi_arready;
            next_cycle();
            wait_cnt++;
            if (!ar_done && wait_cnt > TIMEOUT) report_timeout("read address handshake");
        end
        s_axi_arvalid = 1'b0;
        repeat ($urandom_range(3, 0)) next_cycle();
        s_axi_rready = 1'b1;
        wait_cnt = 0;
        // rready held until rvalid shows up
        while (!r_done && !aborted) begin
            @(negedge AXIS_ACLK);
            r_done = s_axi_rvalid;
            next_cycle();
            wait_cnt++;
            if (!r_done && wait_cnt > TIMEOUT) report_timeout("read data");
        end
        s_axi_rready = 1'b0;
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        if (errors == errs_before && !aborted) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail", num, name);
        end
    endtask

    // ------------------------------------------------------------
    // one generation run with N random in 0..12
    // ------------------------------------------------------------
    task automatic run_generation(input int num, input string label);
        int n;
        int wait_cnt;
        int errs_before;
        n = $urandom_range(12, 0);
        errs_before = errors;
        last_n = n;
        run_start = 1'b1;
        next_cycle();
        run_start = 1'b0;
        write_reg(32'h4, 32'(n), $urandom_range(2, 0));
        write_reg(32'h0, 32'h1, $urandom_range(2, 0));
        wait_cnt = 0;
        while (items_seen < n + 1 && !aborted) begin
            next_cycle();
            wait_cnt++;
            if (wait_cnt > (n + 1) * `HDC_WORDS + TIMEOUT) report_timeout("all item pulses");
        end
        end_test(num, {label, " items 0 to N"}, errs_before);
        errs_before = errors;
        // gen has cleared itself and the stream stays quiet
        read_reg(32'h0, 32'h0);
        repeat (4 * `HDC_WORDS) next_cycle();
        end_test(num + 1, {label, " gen self-clear"}, errs_before);
    endtask

    initial begin
        int errs_before;
        logic [31:0] value;
        void'($urandom(80));
        aborted       = 1'b0;
        S_AXI_ARESETN = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '1;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        exp_rdata     = '0;
        run_start     = 1'b0;
        last_n        = 0;
        repeat (16) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        errs_before = errors;
        read_reg(32'h0, 32'h0);
        read_reg(32'h4, 32'h0);
        end_test(1, "reset state", errs_before);

        errs_before = errors;
        value = '0;
        for (int order = 0; order < 3; order++) begin
            value = 32'($urandom_range(1023, 0));
            write_reg(32'h4, value, order);
            read_reg(32'h4, value);
        end
        // read raised during a write must see the new count
        value = value ^ 32'h3ff;
        fork
            write_reg(32'h4, value, 0);
            read_reg(32'h4, value);
        join
        // unmapped offset and other region
        read_reg(32'h8, 32'h0);
        read_reg(32'h400, 32'h0);
        end_test(2, "item count readback", errs_before);

        if (!aborted) run_generation(3, "first run");
        if (!aborted) run_generation(5, "second run");

        $display("summary: %0d checks, %0d errors, timeout %0d", checks, errors, aborted);
        if (errors == 0 && !aborted) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/axil_pkg.sv
logic/hdc_pkg.sv
logic/axil_slave.sv
logic/ctrl_regs.sv
logic/xorshift_prng.sv
logic/item_vector_gen.sv
logic/hdc_top.sv
tests/hdc_checker.sv
tests/hdc_top_sva.sv
tests/tb_hdc_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_hdc_top -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_hdc_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
